//--- Makefile
TOP = tb_mcu_stream

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module mcu_stream_top

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
+incdir+hw
hw/mcu_pkg.sv
hw/data_bram.sv
hw/axis_skid_buffer.sv
hw/bram_reader.sv
hw/global_fsm.sv
hw/mcu_stream_top.sv
verification/tb_mcu_stream.sv

//--- hw/axis_skid_buffer.sv
`include "mcu_defs.svh"

module axis_skid_buffer
  import mcu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       clear,
  input  axis_beat_t in_beat,
  input  logic       in_valid,
  output logic       in_ready,
  output axis_beat_t out_beat,
  output logic       out_valid,
  input  logic       out_ready
);

  axis_beat_t main_q;
  axis_beat_t skid_q;
  logic       main_valid_q;
  logic       skid_valid_q;
  logic       main_free;
  logic       in_fire;

  // Main register can load when it drains or is empty
  assign main_free = out_ready || !main_valid_q;
  assign in_fire   = in_valid && in_ready;

  // Ready comes straight from a flop
  assign in_ready  = !skid_valid_q;
  assign out_beat  = main_q;
  assign out_valid = main_valid_q;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_free) begin
      if (skid_valid_q) begin
        main_valid_q <= 1'b1;
        skid_valid_q <= 1'b0;
      end else begin
        main_valid_q <= in_fire;
      end
    end else if (in_fire) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid_q) begin
        main_q <= skid_q;
      end else if (in_fire) begin
        main_q <= in_beat;
      end
    end else if (in_fire) begin
      skid_q <= in_beat;
    end
  end

  // Head beat holds while stalled
  a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready && !clear |=> out_valid && $stable(out_beat));

endmodule

//--- hw/bram_reader.sv
`include "mcu_defs.svh"

module bram_reader
  import mcu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  glo_state_e  glo_state,
  input  stream_cfg_t cfg,
  output logic        rd_en,
  output addr_t       rd_addr,
  input  data_t       rd_data,
  input  logic        rd_ack,
  output data_t       m_tdata,
  output logic        m_tvalid,
  input  logic        m_tready,
  output logic        m_tlast,
  output logic        tlast_sent,
  output logic        loc_error
);

  loc_state_e state_q;
  loc_state_e state_d;
  addr_t      addr_q;
  count_t     inter_q;
  count_t     rep_q;
  logic [1:0] credits_q;
  logic       issued_all_q;
  logic       last_pend_q;

  axis_beat_t in_beat;
  axis_beat_t out_beat;
  logic       in_ready;
  logic       out_valid;
  logic       out_ready;

  logic       end_of_sweep;
  logic       final_sweep;
  logic       final_rep;
  logic       release_beat;
  logic       cfg_bad;

  assign end_of_sweep = (span_t'(addr_q) + span_t'(1)) == cfg.addr_count;
  assign final_sweep  = (inter_q + count_t'(1)) == cfg.inter_count;
  assign final_rep    = (rep_q + count_t'(1)) == cfg.intra_count;
  assign release_beat = out_valid && out_ready;
  assign cfg_bad      = (cfg.addr_count == '0) || (cfg.inter_count == '0) ||
                        (cfg.intra_count == '0);

  // Read only while a buffer slot is free or frees up this cycle
  assign rd_en   = (state_q == LOC_OPE) && !issued_all_q &&
                   ((credits_q != 2'd2) || release_beat);
  assign rd_addr = addr_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      LOC_STR: begin
        if (glo_state == GLO_STR) begin
          state_d = cfg_bad ? LOC_ERR : LOC_OPE;
        end
      end
      LOC_OPE: begin
        if (m_tvalid && m_tready && m_tlast) begin
          state_d = LOC_END;
        end
      end
      LOC_END: begin
        if (glo_state == GLO_END) begin
          state_d = LOC_STR;
        end
      end
      LOC_ERR: begin
        if (glo_state == GLO_ERR) begin
          state_d = LOC_STR;
        end
      end
      default: state_d = LOC_STR;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= LOC_STR;
      addr_q       <= '0;
      inter_q      <= '0;
      rep_q        <= '0;
      credits_q    <= '0;
      issued_all_q <= 1'b0;
      last_pend_q  <= 1'b0;
    end else begin
      state_q     <= state_d;
      // Last tag travels beside the RAM read
      last_pend_q <= rd_en && end_of_sweep && final_sweep;
      if (state_q != LOC_OPE) begin
        addr_q       <= '0;
        inter_q      <= '0;
        rep_q        <= '0;
        credits_q    <= '0;
        issued_all_q <= 1'b0;
      end else begin
        credits_q <= credits_q + {1'b0, rd_en} - {1'b0, release_beat};
        if (m_tvalid && m_tready) begin
          rep_q <= final_rep ? '0 : rep_q + count_t'(1);
        end
        if (rd_en) begin
          if (end_of_sweep) begin
            addr_q  <= '0;
            inter_q <= inter_q + count_t'(1);
            if (final_sweep) begin
              issued_all_q <= 1'b1;
            end
          end else begin
            addr_q <= addr_q + addr_t'(1);
          end
        end
      end
    end
  end

  assign in_beat = '{data: rd_data, last: last_pend_q};

  axis_skid_buffer u_skid (
    .clk       (clk),
    .rst       (rst),
    .clear     (state_q == LOC_ERR),
    .in_beat   (in_beat),
    .in_valid  (rd_ack),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  // Head word is popped only after its final repeat
  assign out_ready = m_tready && final_rep;
  assign m_tdata   = out_beat.data;
  assign m_tvalid  = out_valid;
  assign m_tlast   = out_beat.last && final_rep;

  assign tlast_sent = (state_q == LOC_END);
  assign loc_error  = (state_q == LOC_ERR);

  a_rd_in_run: assert property (@(posedge clk) disable iff (rst)
    rd_en |-> (state_q == LOC_OPE) && (glo_state == GLO_RUN));

  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credits_q <= 2'd2);

  // Credit scheme keeps the buffer able to take every returned word
  a_no_drop: assert property (@(posedge clk) disable iff (rst)
    rd_ack |-> in_ready);

endmodule

//--- hw/data_bram.sv
`include "mcu_defs.svh"

module data_bram
  import mcu_pkg::*;
(
  input  logic  clk,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  data_t wr_data,
  input  logic  rd_en,
  input  addr_t rd_addr,
  output data_t rd_data,
  output logic  rd_ack
);

  data_t mem [0:`MCU_DEPTH-1];

  // Host load port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read with data one cycle after enable
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // Ack follows the enable by one cycle
  always_ff @(posedge clk) begin
    rd_ack <= rd_en;
  end

endmodule

//--- hw/global_fsm.sv
`include "mcu_defs.svh"

module global_fsm
  import mcu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  stream_cfg_t cfg_in,
  output stream_cfg_t cfg_q,
  output glo_state_e  glo_state,
  input  logic        tlast_sent,
  input  logic        loc_error,
  output logic        done,
  output logic        error
);

  glo_state_e state_q;
  glo_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      GLO_IDLE: begin
        if (start) begin
          state_d = GLO_STR;
        end
      end
      GLO_STR: state_d = GLO_RUN;
      GLO_RUN: begin
        if (loc_error) begin
          state_d = GLO_ERR;
        end else if (tlast_sent) begin
          state_d = GLO_END;
        end
      end
      GLO_END: state_d = GLO_IDLE;
      GLO_ERR: state_d = GLO_IDLE;
      default: state_d = GLO_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= GLO_IDLE;
      done    <= 1'b0;
      error   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Pulses leave with the state
      done    <= (state_q == GLO_END);
      error   <= (state_q == GLO_ERR);
    end
  end

  // Config is only taken on an accepted start
  always_ff @(posedge clk) begin
    if (start && (state_q == GLO_IDLE)) begin
      cfg_q <= cfg_in;
    end
  end

  assign glo_state = state_q;

  // Reader never reports completion and error at once
  a_one_outcome: assert property (@(posedge clk) disable iff (rst)
    !(tlast_sent && loc_error));

endmodule

//--- hw/mcu_defs.svh
`ifndef MCU_DEFS_SVH
`define MCU_DEFS_SVH

// Stream word width
`define MCU_DATA_W 16

// RAM address width
`define MCU_ADDR_W 8

// Inter (sweep) and intra (repeat) counter width
`define MCU_CNT_W 16

// Number of RAM words, one full address range
`define MCU_DEPTH 256

`endif

//--- hw/mcu_pkg.sv
`include "mcu_defs.svh"

package mcu_pkg;

  typedef logic [`MCU_DATA_W-1:0] data_t;
  typedef logic [`MCU_ADDR_W-1:0] addr_t;
  // One bit wider than addr_t so a sweep over the whole RAM fits
  typedef logic [`MCU_ADDR_W:0]   span_t;
  typedef logic [`MCU_CNT_W-1:0]  count_t;

  // Run sequencer states
  typedef enum logic [2:0] {
    GLO_IDLE,
    GLO_STR,
    GLO_RUN,
    GLO_END,
    GLO_ERR
  } glo_state_e;

  // Local reader states
  typedef enum logic [1:0] {
    LOC_STR,
    LOC_OPE,
    LOC_ERR,
    LOC_END
  } loc_state_e;

  typedef struct packed {
    span_t  addr_count;
    count_t inter_count;
    count_t intra_count;
  } stream_cfg_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } axis_beat_t;

endpackage

//--- hw/mcu_stream_top.sv
`include "mcu_defs.svh"

module mcu_stream_top
  import mcu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        load_en,
  input  addr_t       load_addr,
  input  data_t       load_data,
  input  logic        start,
  input  stream_cfg_t cfg,
  output data_t       m_tdata,
  output logic        m_tvalid,
  input  logic        m_tready,
  output logic        m_tlast,
  output logic        done,
  output logic        error
);

  stream_cfg_t cfg_q;
  glo_state_e  glo_state;
  logic        tlast_sent;
  logic        loc_error;
  logic        rd_en;
  logic        rd_ack;
  addr_t       rd_addr;
  data_t       rd_data;

  data_bram u_bram (
    .clk     (clk),
    .wr_en   (load_en),
    .wr_addr (load_addr),
    .wr_data (load_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rd_ack  (rd_ack)
  );

  bram_reader u_reader (
    .clk        (clk),
    .rst        (rst),
    .glo_state  (glo_state),
    .cfg        (cfg_q),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .rd_ack     (rd_ack),
    .m_tdata    (m_tdata),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tlast    (m_tlast),
    .tlast_sent (tlast_sent),
    .loc_error  (loc_error)
  );

  global_fsm u_global (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .cfg_in     (cfg),
    .cfg_q      (cfg_q),
    .glo_state  (glo_state),
    .tlast_sent (tlast_sent),
    .loc_error  (loc_error),
    .done       (done),
    .error      (error)
  );

endmodule

//--- verification/tb_mcu_stream.sv
`include "mcu_defs.svh"

module tb_mcu_stream
  import mcu_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CYCLE_LIMIT = 20000;

  logic        clk;
  logic        rst;
  logic        load_en;
  addr_t       load_addr;
  data_t       load_data;
  logic        start;
  stream_cfg_t cfg;
  data_t       m_tdata;
  logic        m_tvalid;
  logic        m_tready;
  logic        m_tlast;
  logic        done;
  logic        error;

  data_t      model_mem [0:`MCU_DEPTH-1];
  axis_beat_t exp_q [$];
  int         errors;
  int         beats;
  int         done_cnt;
  int         err_cnt;
  int         cycles;
  logic       bp_en;
  logic       stall_q;
  data_t      held_data;
  logic       held_last;

  mcu_stream_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .start     (start),
    .cfg       (cfg),
    .m_tdata   (m_tdata),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready),
    .m_tlast   (m_tlast),
    .done      (done),
    .error     (error)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Sink ready is random only while back-pressure is on
  always @(posedge clk) begin
    m_tready <= bp_en ? ($urandom_range(0, 1) == 1) : 1'b1;
  end

  // Beat monitor, pulse counters and stall check
  always @(posedge clk) begin
    axis_beat_t want;
    if (!rst) begin
      if (done) done_cnt++;
      if (error) err_cnt++;
      if (stall_q && !m_tvalid) begin
        $display("m_tvalid dropped during a stall at %0t", $time);
        errors++;
      end else if (stall_q && (m_tdata !== held_data || m_tlast !== held_last)) begin
        $display("** Error at %0t: m_tdata/m_tlast in stall expected %h/%b got %h/%b",
                 $time, held_data, held_last, m_tdata, m_tlast);
        errors++;
      end
      if (m_tvalid && m_tready) begin
        beats++;
        if (exp_q.size() == 0) begin
          $display("Unexpected beat %h at %0t, no beat was due", m_tdata, $time);
          errors++;
        end else begin
          want = exp_q.pop_front();
          if (m_tdata !== want.data) begin
            $display("** Error at %0t: m_tdata expected %h got %h",
                     $time, want.data, m_tdata);
            errors++;
          end
          if (m_tlast !== want.last) begin
            $display("** Error at %0t: m_tlast expected %b got %b",
                     $time, want.last, m_tlast);
            errors++;
          end
        end
      end
      stall_q   = m_tvalid && !m_tready;
      held_data = m_tdata;
      held_last = m_tlast;
    end
  end

  // Run limit well beyond the length of all tests
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("Beats checked: %0d, errors: %0d", beats, errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic stream_cfg_t make_cfg(input int addrs, input int sweeps, input int reps);
    stream_cfg_t c;
    c.addr_count  = span_t'(addrs);
    c.inter_count = count_t'(sweeps);
    c.intra_count = count_t'(reps);
    return c;
  endfunction

  task automatic load_ram();
    data_t w;
    for (int a = 0; a < `MCU_DEPTH; a++) begin
      w = data_t'($urandom);
      model_mem[a] = w;
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= addr_t'(a);
      load_data <= w;
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  // Each sweep walks the addresses and repeats each word intra_count times
  task automatic build_expected(input stream_cfg_t c);
    axis_beat_t b;
    int sweeps;
    int addrs;
    int reps;
    sweeps = int'(c.inter_count);
    addrs  = int'(c.addr_count);
    reps   = int'(c.intra_count);
    exp_q.delete();
    for (int s = 0; s < sweeps; s++) begin
      for (int a = 0; a < addrs; a++) begin
        for (int r = 0; r < reps; r++) begin
          b.data = model_mem[a];
          b.last = (s == sweeps - 1) && (a == addrs - 1) && (r == reps - 1);
          exp_q.push_back(b);
        end
      end
    end
  endtask

  task automatic pulse_start(input stream_cfg_t c);
    @(posedge clk);
    start <= 1'b1;
    cfg   <= c;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic launch_run(input stream_cfg_t c);
    build_expected(c);
    done_cnt = 0;
    err_cnt  = 0;
    pulse_start(c);
  endtask

  // Wait for the run outcome, then let both FSMs settle back to idle
  task automatic await_finish(input bit expect_done);
    while (!(done || error)) @(posedge clk);
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0) begin
      $display("Run ended with %0d expected beats never sent", exp_q.size());
      errors++;
    end
    if (expect_done && done_cnt == 0) begin
      $display("Run ended without a done pulse at %0t", $time);
      errors++;
    end else if (done_cnt != (expect_done ? 1 : 0)) begin
      $display("** Error at %0t: done pulses expected %0d got %0d",
               $time, expect_done ? 1 : 0, done_cnt);
      errors++;
    end
    if (err_cnt != (expect_done ? 0 : 1)) begin
      $display("** Error at %0t: error pulses expected %0d got %0d",
               $time, expect_done ? 0 : 1, err_cnt);
      errors++;
    end
    exp_q.delete();
  endtask

  task automatic basic_run();
    launch_run(make_cfg(4, 1, 1));
    await_finish(1'b1);
  endtask

  task automatic repeat_sweeps();
    launch_run(make_cfg(3, 2, 3));
    await_finish(1'b1);
  endtask

  task automatic random_backpressure();
    bp_en <= 1'b1;
    launch_run(make_cfg(16, 2, 2));
    await_finish(1'b1);
    bp_en <= 1'b0;
  endtask

  task automatic zero_count_errors();
    launch_run(make_cfg(0, 2, 2));
    await_finish(1'b0);
    launch_run(make_cfg(4, 0, 2));
    await_finish(1'b0);
    launch_run(make_cfg(4, 2, 0));
    await_finish(1'b0);
    // Unit must recover for a normal run
    launch_run(make_cfg(5, 1, 2));
    await_finish(1'b1);
  endtask

  task automatic full_ram_sweep();
    load_ram();
    launch_run(make_cfg(256, 1, 1));
    await_finish(1'b1);
  endtask

  task automatic busy_start_ignored();
    launch_run(make_cfg(8, 2, 2));
    repeat (10) @(posedge clk);
    pulse_start(make_cfg(2, 1, 1));
    await_finish(1'b1);
  endtask

  initial begin
    void'($urandom(10205));
    rst       = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    start     = 1'b0;
    cfg       = '0;
    m_tready  = 1'b1;
    bp_en     = 1'b0;
    stall_q   = 1'b0;
    held_data = '0;
    held_last = 1'b0;
    errors    = 0;
    beats     = 0;
    done_cnt  = 0;
    err_cnt   = 0;
    cycles    = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    load_ram();
    basic_run();
    repeat_sweeps();
    random_backpressure();
    zero_count_errors();
    full_ram_sweep();
    busy_start_ignored();
    $display("Beats checked: %0d, errors: %0d", beats, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
